// ==== source/cordic_pkg.sv ====
package cordic_pkg;

    localparam int DATA_W     = 16;                 // Width of x, y and z words
    localparam int PROD_W     = 2 * DATA_W;         // Full gain product width
    localparam int ITERATIONS = 12;                 // Micro-rotations per item
    localparam int ITER_W     = 4;                  // Iteration counter width

    // Angle scale is 2*pi == 65536
    localparam logic signed [DATA_W-1:0] ANGLE_HALF_PI = 16'sd16384;  // pi/2
    localparam logic [DATA_W-1:0]        ANGLE_PI      = 16'd32768;   // pi, wraps to sign bit

    // 1/K for 12 stages, Q1.15
    localparam logic signed [DATA_W-1:0] GAIN_INV   = 16'sd19898;
    localparam int                       GAIN_SHIFT = 15;             // Q15 back to integer

    localparam logic OP_ROTATE = 1'b0;              // Drive z towards zero
    localparam logic OP_VECTOR = 1'b1;              // Drive y towards zero

    // arctan(2^-idx) in angle units
    function automatic logic signed [DATA_W-1:0] atan_entry(input logic [ITER_W-1:0] idx);
        logic signed [DATA_W-1:0] val;
        case (idx)
            4'd0:    val = 16'sd8192;               // 45 deg
            4'd1:    val = 16'sd4836;
            4'd2:    val = 16'sd2555;
            4'd3:    val = 16'sd1297;
            4'd4:    val = 16'sd651;
            4'd5:    val = 16'sd326;
            4'd6:    val = 16'sd163;
            4'd7:    val = 16'sd81;
            4'd8:    val = 16'sd41;
            4'd9:    val = 16'sd20;
            4'd10:   val = 16'sd10;
            4'd11:   val = 16'sd5;                  // Last used entry
            default: val = '0;                      // Beyond table, never stepped
        endcase
        return val;
    endfunction

endpackage

// ==== source/quadrant_fold.sv ====
`timescale 1ns/100ps

module quadrant_fold (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 start,      // One-cycle request strobe
    input  logic                                 busy,       // Downstream still occupied
    input  logic                                 op,         // Mode bit for this item
    input  logic signed [cordic_pkg::DATA_W-1:0] x_in,
    input  logic signed [cordic_pkg::DATA_W-1:0] y_in,
    input  logic signed [cordic_pkg::DATA_W-1:0] z_in,
    output logic                                 fold_valid, // Pulse towards the engine
    output logic                                 fold_op,
    output logic signed [cordic_pkg::DATA_W-1:0] fold_x,
    output logic signed [cordic_pkg::DATA_W-1:0] fold_y,
    output logic signed [cordic_pkg::DATA_W-1:0] fold_z
);

    logic                                 accept;       // Start taken this cycle
    logic                                 z_out_range;  // |z| beyond pi/2
    logic                                 x_negative;   // Left half plane
    logic                                 flip;         // Rotate item by pi
    logic signed [cordic_pkg::DATA_W-1:0] x_fold;
    logic signed [cordic_pkg::DATA_W-1:0] y_fold;
    logic signed [cordic_pkg::DATA_W-1:0] z_fold;

    assign accept = start && !busy;                     // Starts while busy are lost

    // Rotation range check, both limits inclusive
    assign z_out_range = (z_in > cordic_pkg::ANGLE_HALF_PI) ||
                         (z_in < -cordic_pkg::ANGLE_HALF_PI);
    assign x_negative  = x_in[cordic_pkg::DATA_W-1];

    // Mode decides which quantity is folded
    assign flip = (op == cordic_pkg::OP_VECTOR) ? x_negative : z_out_range;

    // Half turn, negate vector and shift angle by pi
    always_comb begin
        if (flip) begin
            x_fold = -x_in;
            y_fold = -y_in;
            z_fold = z_in + $signed(cordic_pkg::ANGLE_PI);   // Modulo 2^16
        end else begin
            x_fold = x_in;
            y_fold = y_in;
            z_fold = z_in;
        end
    end

    // Item register, held until the next accepted start
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fold_valid <= 1'b0;
            fold_op    <= 1'b0;
            fold_x     <= '0;
            fold_y     <= '0;
            fold_z     <= '0;
        end else begin
            fold_valid <= accept;                       // Single-cycle pulse
            if (accept) begin
                fold_op <= op;
                fold_x  <= x_fold;
                fold_y  <= y_fold;
                fold_z  <= z_fold;
            end
        end
    end

endmodule

// ==== source/cordic_core.sv ====
`timescale 1ns/100ps

module cordic_core (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 load,    // Item present on inputs
    input  logic                                 op,      // Mode of the loaded item
    input  logic signed [cordic_pkg::DATA_W-1:0] x_in,
    input  logic signed [cordic_pkg::DATA_W-1:0] y_in,
    input  logic signed [cordic_pkg::DATA_W-1:0] z_in,
    output logic                                 done,    // Result strobe
    output logic                                 busy,    // Engine occupied
    output logic signed [cordic_pkg::DATA_W-1:0] x_out,
    output logic signed [cordic_pkg::DATA_W-1:0] y_out,
    output logic signed [cordic_pkg::DATA_W-1:0] z_out
);

    typedef enum logic [1:0] {
        st_idle,                                          // Waiting for load
        st_setup,                                         // Operands loaded, first step
        st_iterate,                                       // Remaining micro-rotations
        st_finish                                         // Hand result over
    } state_t;

    localparam logic [cordic_pkg::ITER_W-1:0] LAST_ITER =
        cordic_pkg::ITER_W'(cordic_pkg::ITERATIONS - 1);

    state_t                               state;
    state_t                               next_state;
    logic                                 op_q;           // Mode latched per item
    logic [cordic_pkg::ITER_W-1:0]        iteration;      // Also the shift amount
    logic signed [cordic_pkg::DATA_W-1:0] x;
    logic signed [cordic_pkg::DATA_W-1:0] y;
    logic signed [cordic_pkg::DATA_W-1:0] z;
    logic signed [cordic_pkg::DATA_W-1:0] x_next;
    logic signed [cordic_pkg::DATA_W-1:0] y_next;
    logic signed [cordic_pkg::DATA_W-1:0] z_next;
    logic signed [cordic_pkg::DATA_W-1:0] shift_x;
    logic signed [cordic_pkg::DATA_W-1:0] shift_y;
    logic signed [cordic_pkg::DATA_W-1:0] atan_val;
    logic                                 dir_pos;        // d == +1

    assign busy = (state != st_idle);                     // Low again in the done cycle

    // Sequencer and working registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= st_idle;
            op_q      <= 1'b0;
            iteration <= '0;
            x         <= '0;
            y         <= '0;
            z         <= '0;
            done      <= 1'b0;
            x_out     <= '0;
            y_out     <= '0;
            z_out     <= '0;
        end else begin
            state <= next_state;
            done  <= 1'b0;                                // Pulse by default
            case (state)
                st_idle: begin
                    if (load) begin
                        op_q      <= op;
                        x         <= x_in;
                        y         <= y_in;
                        z         <= z_in;
                        iteration <= '0;
                    end
                end
                st_setup, st_iterate: begin
                    x         <= x_next;                  // Setup leaves after stage 0
                    y         <= y_next;
                    z         <= z_next;
                    iteration <= iteration + 1'b1;
                end
                st_finish: begin
                    done  <= 1'b1;
                    x_out <= x;                           // Held for the gain stage
                    y_out <= y;
                    z_out <= z;
                end
                default: begin
                end
            endcase
        end
    end

    // Next-state logic
    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (load) begin
                    next_state = st_setup;
                end
            end
            st_setup: begin
                next_state = st_iterate;
            end
            st_iterate: begin
                if (iteration == LAST_ITER) begin
                    next_state = st_finish;               // Stage 11 done this edge
                end
            end
            st_finish: begin
                next_state = st_idle;
            end
            default: begin
                next_state = st_idle;
            end
        endcase
    end

    // Shift-add datapath
    assign shift_x  = x >>> iteration;                    // Sign kept
    assign shift_y  = y >>> iteration;
    assign atan_val = cordic_pkg::atan_entry(iteration);

    // Rotation follows sign of z, vectoring drives y to zero
    assign dir_pos = (op_q == cordic_pkg::OP_ROTATE) ? ~z[cordic_pkg::DATA_W-1]
                                                     : y[cordic_pkg::DATA_W-1];

    always_comb begin
        if (dir_pos) begin
            x_next = x - shift_y;                         // Counter-clockwise
            y_next = y + shift_x;
            z_next = z - atan_val;
        end else begin
            x_next = x + shift_y;                         // Clockwise
            y_next = y - shift_x;
            z_next = z + atan_val;
        end
    end

endmodule

// ==== source/gain_comp.sv ====
`timescale 1ns/100ps

module gain_comp (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 valid_in,  // Engine result strobe
    input  logic signed [cordic_pkg::DATA_W-1:0] x_in,
    input  logic signed [cordic_pkg::DATA_W-1:0] y_in,
    input  logic signed [cordic_pkg::DATA_W-1:0] z_in,
    output logic                                 out_valid, // Final result strobe
    output logic signed [cordic_pkg::DATA_W-1:0] x_out,
    output logic signed [cordic_pkg::DATA_W-1:0] y_out,
    output logic signed [cordic_pkg::DATA_W-1:0] z_out
);

    logic signed [cordic_pkg::PROD_W-1:0] x_prod;   // Q15 scaled x
    logic signed [cordic_pkg::PROD_W-1:0] y_prod;   // Q15 scaled y
    logic signed [cordic_pkg::DATA_W-1:0] x_comp;
    logic signed [cordic_pkg::DATA_W-1:0] y_comp;

    // Full-width signed products, no overflow possible
    assign x_prod = x_in * cordic_pkg::GAIN_INV;
    assign y_prod = y_in * cordic_pkg::GAIN_INV;

    // Drop fraction bits, truncation towards minus infinity
    assign x_comp = cordic_pkg::DATA_W'(x_prod >>> cordic_pkg::GAIN_SHIFT);
    assign y_comp = cordic_pkg::DATA_W'(y_prod >>> cordic_pkg::GAIN_SHIFT);

    // Output register, values stay until next item
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            x_out     <= '0;
            y_out     <= '0;
            z_out     <= '0;
        end else begin
            out_valid <= valid_in;                   // One cycle per result
            if (valid_in) begin
                x_out <= x_comp;
                y_out <= y_comp;
                z_out <= z_in;                       // Angle needs no gain fix
            end
        end
    end

endmodule

// ==== source/cordic_unit.sv ====
`timescale 1ns/100ps

module cordic_unit (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 start,     // Request strobe
    input  logic                                 op,        // 0 rotate, 1 vector
    input  logic signed [cordic_pkg::DATA_W-1:0] x_in,
    input  logic signed [cordic_pkg::DATA_W-1:0] y_in,
    input  logic signed [cordic_pkg::DATA_W-1:0] z_in,
    output logic                                 out_valid, // Result strobe
    output logic signed [cordic_pkg::DATA_W-1:0] x_out,
    output logic signed [cordic_pkg::DATA_W-1:0] y_out,
    output logic signed [cordic_pkg::DATA_W-1:0] z_out,
    output logic                                 busy       // Starts ignored while high
);

    // Fold stage to engine
    logic                                 fold_valid;
    logic                                 fold_op;
    logic signed [cordic_pkg::DATA_W-1:0] fold_x;
    logic signed [cordic_pkg::DATA_W-1:0] fold_y;
    logic signed [cordic_pkg::DATA_W-1:0] fold_z;

    // Engine to gain stage
    logic                                 core_done;
    logic                                 core_busy;
    logic signed [cordic_pkg::DATA_W-1:0] core_x;
    logic signed [cordic_pkg::DATA_W-1:0] core_y;
    logic signed [cordic_pkg::DATA_W-1:0] core_z;

    logic                                 hold;         // Item between fold and done

    // Covers the gap before the engine leaves idle
    assign hold = core_busy | fold_valid;
    assign busy = hold;

    quadrant_fold i_fold (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .busy       (hold),
        .op         (op),
        .x_in       (x_in),
        .y_in       (y_in),
        .z_in       (z_in),
        .fold_valid (fold_valid),
        .fold_op    (fold_op),
        .fold_x     (fold_x),
        .fold_y     (fold_y),
        .fold_z     (fold_z)
    );

    cordic_core i_core (
        .clk   (clk),
        .rst_n (rst_n),
        .load  (fold_valid),
        .op    (fold_op),
        .x_in  (fold_x),
        .y_in  (fold_y),
        .z_in  (fold_z),
        .done  (core_done),
        .busy  (core_busy),
        .x_out (core_x),
        .y_out (core_y),
        .z_out (core_z)
    );

    gain_comp i_gain (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_in  (core_done),
        .x_in      (core_x),
        .y_in      (core_y),
        .z_in      (core_z),
        .out_valid (out_valid),
        .x_out     (x_out),
        .y_out     (y_out),
        .z_out     (z_out)
    );

endmodule

// ==== bench/cordic_model.svh ====
`ifndef CORDIC_MODEL_SVH
`define CORDIC_MODEL_SVH

// Next state of a 32-bit xorshift generator
function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] v;
    v = s ^ (s << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
endfunction

// arctan(2^-i) rounded to angle units, 2*pi == 65536
function automatic logic signed [cordic_pkg::DATA_W-1:0] atan_units(input int i);
    real frac;
    frac = 1.0;
    repeat (i) begin
        frac = frac / 2.0;
    end
    return cordic_pkg::DATA_W'($rtoi($atan(frac) * 32768.0 / 3.14159265358979 + 0.5));
endfunction

// Fold, twelve micro-rotations and gain for one item
function automatic void compute_expected(
    input  logic                                 op_v,
    input  logic signed [cordic_pkg::DATA_W-1:0] x_v,
    input  logic signed [cordic_pkg::DATA_W-1:0] y_v,
    input  logic signed [cordic_pkg::DATA_W-1:0] z_v,
    output logic signed [cordic_pkg::DATA_W-1:0] x_e,
    output logic signed [cordic_pkg::DATA_W-1:0] y_e,
    output logic signed [cordic_pkg::DATA_W-1:0] z_e
);
    logic signed [cordic_pkg::DATA_W-1:0] x;
    logic signed [cordic_pkg::DATA_W-1:0] y;
    logic signed [cordic_pkg::DATA_W-1:0] z;
    logic signed [cordic_pkg::DATA_W-1:0] x_sh;
    logic signed [cordic_pkg::DATA_W-1:0] y_sh;
    int                                   i;
    int                                   x_prod;
    int                                   y_prod;
    bit                                   flip;
    bit                                   d_pos;
    x = x_v;
    y = y_v;
    z = z_v;
    if (op_v == cordic_pkg::OP_VECTOR) begin
        flip = x[cordic_pkg::DATA_W-1];                   // Left half plane
    end else begin
        flip = (int'(z) > int'(cordic_pkg::ANGLE_HALF_PI)) ||
               (int'(z) < -int'(cordic_pkg::ANGLE_HALF_PI));
    end
    if (flip) begin
        x = -x;
        y = -y;
        z = cordic_pkg::DATA_W'(int'(z) + 32768);        // Plus pi, wraps
    end
    for (i = 0; i < cordic_pkg::ITERATIONS; i++) begin
        if (op_v == cordic_pkg::OP_VECTOR) begin
            d_pos = y[cordic_pkg::DATA_W-1];               // y negative
        end else begin
            d_pos = !z[cordic_pkg::DATA_W-1];              // z non-negative
        end
        x_sh = x >>> i;
        y_sh = y >>> i;
        if (d_pos) begin
            x = x - y_sh;
            y = y + x_sh;
            z = z - atan_units(i);
        end else begin
            x = x + y_sh;
            y = y - x_sh;
            z = z + atan_units(i);
        end
    end
    x_prod = int'(x) * int'(cordic_pkg::GAIN_INV);        // Q15 product
    y_prod = int'(y) * int'(cordic_pkg::GAIN_INV);
    x_e = cordic_pkg::DATA_W'(x_prod >>> cordic_pkg::GAIN_SHIFT);
    y_e = cordic_pkg::DATA_W'(y_prod >>> cordic_pkg::GAIN_SHIFT);
    z_e = z;
endfunction

`endif

// ==== bench/tb_cordic_unit.sv ====
`timescale 1ns/100ps

module tb_cordic_unit;

    typedef logic signed [cordic_pkg::DATA_W-1:0] word_t;

    localparam int    LATENCY     = 15;             // Start edge to out_valid
    localparam int    BUSY_CYCLES = LATENCY - 1;    // busy falls as core_done rises
    localparam int    TIMEOUT     = 40;
    localparam int    N_RANDOM    = 200;
    localparam int    N_B2B       = 24;
    localparam int    DROP_DELAY  = 5;              // Cycles from first start to second
    localparam word_t RESIDUE_MAX = 16'sd8;         // Vectoring y_out bound

    logic        clk = 1'b0;
    logic        rst_n;
    logic        start;
    logic        op;
    word_t       x_in;
    word_t       y_in;
    word_t       z_in;
    logic        out_valid;
    word_t       x_out;
    word_t       y_out;
    word_t       z_out;
    logic        busy;

    logic [31:0] rng_state;
    int          cycle;
    int          last_valid_cycle;                  // Cycle of previous out_valid or -1
    int          test_errors;
    int          tests_passed;
    int          tests_failed;
    word_t       exp_x[$];                          // Results still in flight
    word_t       exp_y[$];
    word_t       exp_z[$];

    `include "cordic_model.svh"

    always #20 clk = ~clk;                          // 40 ns period

    cordic_unit i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .op        (op),
        .x_in      (x_in),
        .y_in      (y_in),
        .z_in      (z_in),
        .out_valid (out_valid),
        .x_out     (x_out),
        .y_out     (y_out),
        .z_out     (z_out),
        .busy      (busy)
    );

    // Step to just after the next rising edge
    task automatic tick();
        @(posedge clk);
        #2;
        cycle++;
    endtask

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic word_t random_coord();
        int v;
        v = int'(next_random() % 32'd16383) - 8191;  // |v| below 8192
        return word_t'(v);
    endfunction

    task automatic report_failure(input string name, input string msg);
        $display("%s: %s", name, msg);
        test_errors++;
    endtask

    task automatic compare_word(input string name, input string label, input word_t exp,
                                input word_t act);
        if (act !== exp) begin
            $display("MISMATCH %s %s: expected %0d, actual %0d", name, label, exp, act);
            test_errors++;
        end
    endtask

    task automatic compare_int(input string name, input string label, input int exp,
                               input int act);
        if (act != exp) begin
            $display("MISMATCH %s %s: expected %0d, actual %0d", name, label, exp, act);
            test_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0) begin
            tests_passed++;
            $display("PASS %s", name);
        end else begin
            tests_failed++;
            $display("FAIL %s, %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    // Counts edges after the start edge until out_valid
    task automatic wait_for_result(input string name, output bit seen, output int cycles);
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < TIMEOUT) begin
            tick();
            cycles++;
            seen = out_valid;
        end
        if (!seen) begin
            report_failure(name, $sformatf("no out_valid within %0d cycles", TIMEOUT));
        end
    endtask

    // Runs one item and checks it against the model
    task automatic run_item(input string name, input logic op_v, input word_t x_v,
                            input word_t y_v, input word_t z_v);
        word_t x_e;
        word_t y_e;
        word_t z_e;
        bit    seen;
        int    cycles;
        compute_expected(op_v, x_v, y_v, z_v, x_e, y_e, z_e);
        if (busy) begin
            report_failure(name, "busy was still high before start");
        end
        op    = op_v;
        x_in  = x_v;
        y_in  = y_v;
        z_in  = z_v;
        start = 1'b1;
        tick();                                     // Start sampled here
        start = 1'b0;
        wait_for_result(name, seen, cycles);
        if (seen) begin
            compare_int(name, "latency", LATENCY, cycles);
            compare_word(name, "x_out", x_e, x_out);
            compare_word(name, "y_out", y_e, y_out);
            compare_word(name, "z_out", z_e, z_out);
        end
    endtask

    // Pops the oldest expected result on each out_valid
    task automatic collect_output(input string name);
        word_t x_e;
        word_t y_e;
        word_t z_e;
        if (out_valid) begin
            if (exp_x.size() == 0) begin
                report_failure(name, "out_valid with no item outstanding");
            end else begin
                x_e = exp_x.pop_front();
                y_e = exp_y.pop_front();
                z_e = exp_z.pop_front();
                compare_word(name, "x_out", x_e, x_out);
                compare_word(name, "y_out", y_e, y_out);
                compare_word(name, "z_out", z_e, z_out);
            end
            if (last_valid_cycle >= 0) begin
                compare_int(name, "result spacing", LATENCY, cycle - last_valid_cycle);
            end
            last_valid_cycle = cycle;
        end
    endtask

    task automatic check_reset_state();
        repeat (10) begin
            tick();
            if (out_valid) begin
                report_failure("reset_state", "out_valid rose without a start");
            end
            if (busy) begin
                report_failure("reset_state", "busy rose without a start");
            end
        end
        compare_word("reset_state", "x_out", word_t'(0), x_out);
        compare_word("reset_state", "y_out", word_t'(0), y_out);
        compare_word("reset_state", "z_out", word_t'(0), z_out);
        finish_test("reset_state");
    endtask

    task automatic run_random_items(input string name, input logic op_v);
        word_t x_v;
        word_t y_v;
        word_t z_v;
        repeat (N_RANDOM) begin
            x_v = random_coord();
            y_v = random_coord();
            z_v = word_t'(next_random() >> 16);     // Full angle range
            run_item(name, op_v, x_v, y_v, z_v);
            if (op_v == cordic_pkg::OP_VECTOR &&
                (y_out > RESIDUE_MAX || y_out < -RESIDUE_MAX)) begin
                report_failure(name, $sformatf("y residue %0d beyond +/-8", y_out));
            end
        end
        finish_test(name);
    endtask

    task automatic run_fold_corners();
        run_item("fold_corners", cordic_pkg::OP_ROTATE, 16'sd5000, -16'sd3000, -16'sd32768);
        run_item("fold_corners", cordic_pkg::OP_ROTATE, 16'sd5000, -16'sd3000, -16'sd16385);
        run_item("fold_corners", cordic_pkg::OP_ROTATE, 16'sd5000, -16'sd3000, 16'sd16384);
        run_item("fold_corners", cordic_pkg::OP_ROTATE, 16'sd5000, -16'sd3000, 16'sd32767);
        run_item("fold_corners", cordic_pkg::OP_VECTOR, -16'sd6000, 16'sd0, 16'sd1000);
        run_item("fold_corners", cordic_pkg::OP_ROTATE, 16'sd0, 16'sd0, 16'sd12345);
        run_item("fold_corners", cordic_pkg::OP_VECTOR, 16'sd0, 16'sd0, 16'sd12345);
        finish_test("fold_corners");
    endtask

    task automatic check_drop_while_busy();
        word_t x_e;
        word_t y_e;
        word_t z_e;
        int    cyc;
        int    busy_cycles;
        bit    seen;
        compute_expected(cordic_pkg::OP_ROTATE, 16'sd3000, 16'sd4000, 16'sd5461, x_e, y_e, z_e);
        op    = cordic_pkg::OP_ROTATE;
        x_in  = 16'sd3000;
        y_in  = 16'sd4000;
        z_in  = 16'sd5461;
        start = 1'b1;
        tick();                                     // Accepted start
        busy_cycles = busy ? 1 : 0;
        cyc  = 0;
        seen = 1'b0;
        while (!seen && cyc < TIMEOUT) begin
            start = (cyc == DROP_DELAY - 1) ||      // Second start lands while busy
                    (cyc == BUSY_CYCLES - 1);       // Another in the last busy cycle
            if (start) begin
                op   = cordic_pkg::OP_VECTOR;
                x_in = -16'sd2000;
                y_in = 16'sd1500;
                z_in = -16'sd700;
            end
            tick();
            cyc++;
            busy_cycles += busy ? 1 : 0;
            seen = out_valid;
        end
        start = 1'b0;
        if (!seen) begin
            report_failure("drop_while_busy", "no out_valid for the accepted start");
        end else begin
            compare_int("drop_while_busy", "latency", LATENCY, cyc);
            compare_int("drop_while_busy", "busy cycles", BUSY_CYCLES, busy_cycles);
            compare_word("drop_while_busy", "x_out", x_e, x_out);
            compare_word("drop_while_busy", "y_out", y_e, y_out);
            compare_word("drop_while_busy", "z_out", z_e, z_out);
        end
        repeat (TIMEOUT) begin
            tick();
            if (out_valid) begin
                report_failure("drop_while_busy", "dropped start produced an out_valid");
            end
            if (busy) begin
                report_failure("drop_while_busy", "busy rose again after the drop");
            end
        end
        finish_test("drop_while_busy");
    endtask

    task automatic run_back_to_back();
        word_t x_v;
        word_t y_v;
        word_t z_v;
        word_t x_e;
        word_t y_e;
        word_t z_e;
        logic  op_v;
        int    n;
        int    waited;
        last_valid_cycle = -1;
        for (n = 0; n < N_B2B; n++) begin
            op_v = n[0];                            // Alternate modes
            x_v  = random_coord();
            y_v  = random_coord();
            z_v  = word_t'(next_random() >> 16);
            compute_expected(op_v, x_v, y_v, z_v, x_e, y_e, z_e);
            exp_x.push_back(x_e);
            exp_y.push_back(y_e);
            exp_z.push_back(z_e);
            op    = op_v;
            x_in  = x_v;
            y_in  = y_v;
            z_in  = z_v;
            start = 1'b1;
            tick();                                 // Previous result may land here
            collect_output("back_to_back");
            start = 1'b0;
            if (!busy) begin
                report_failure("back_to_back", "start was not accepted");
            end
            waited = 0;
            do begin
                tick();
                collect_output("back_to_back");
                waited++;
            end while (busy && waited < TIMEOUT);
            if (busy) begin
                report_failure("back_to_back", "busy stayed high past the timeout");
            end
        end
        waited = 0;
        while (exp_x.size() > 0 && waited < TIMEOUT) begin
            tick();
            collect_output("back_to_back");
            waited++;
        end
        if (exp_x.size() > 0) begin
            report_failure("back_to_back", "last result never arrived");
        end
        finish_test("back_to_back");
    endtask

    initial begin
        rst_n        = 1'b0;
        start        = 1'b0;
        op           = 1'b0;
        x_in         = '0;
        y_in         = '0;
        z_in         = '0;
        rng_state    = 32'd35;
        cycle        = 0;
        test_errors  = 0;
        tests_passed = 0;
        tests_failed = 0;
        last_valid_cycle = -1;
        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;
        check_reset_state();
        run_random_items("rotation", cordic_pkg::OP_ROTATE);
        run_random_items("vectoring", cordic_pkg::OP_VECTOR);
        run_fold_corners();
        check_drop_while_busy();
        run_back_to_back();
        $display("Tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+bench
source/cordic_pkg.sv
source/quadrant_fold.sv
source/cordic_core.sv
source/gain_comp.sv
source/cordic_unit.sv
bench/tb_cordic_unit.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the CORDIC testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps -f verilog.f \
    --top-module tb_cordic_unit -o tb_cordic_unit

./obj_dir/tb_cordic_unit | tee sim.log

if grep -q 'Test failures found' sim.log; then
    echo "Simulation reported failures"
    exit 1
fi
if ! grep -q 'All tests passed!' sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation passed"
